/* biu_ahb_params.svh */
// bus interface unit subsystem parameters
// widths, slave memory depth and register reset values
`ifndef BIU_AHB_PARAMS_SVH
`define BIU_AHB_PARAMS_SVH

// data path and address widths
`define BIU_XLEN 32
`define BIU_PLEN 32

// sram slave geometry
`define SRAM_WORDS 256
`define SRAM_AW 8                          // word index bits

// axi4-lite config port
`define CFG_AW 4                           // byte address, 4 registers
`define CFG_WAIT_W 4                       // wait state field
`define CFG_CNT_W 16                       // error counter

// reset values
`define CFG_WAIT_RST 4'h0                  // no wait states
`define CFG_ERR_BASE_RST {`SRAM_AW{1'b1}}  // base above limit, window empty
`define CFG_ERR_LIMIT_RST {`SRAM_AW{1'b0}}
`define HPROT_RST 4'b0011                  // data, privileged

`endif

/* biu_ahb_pkg.sv */
// shared types for the biu to ahb-lite subsystem
// burst codes, ahb fields, slave states, register map
package biu_ahb_pkg;

  // core side burst type
  typedef enum logic [2:0] {
    SINGLE = 3'd0,
    INCR   = 3'd1,
    WRAP4  = 3'd2,
    INCR4  = 3'd3,
    WRAP8  = 3'd4,
    INCR8  = 3'd5,
    WRAP16 = 3'd6,
    INCR16 = 3'd7
  } biu_burst_e;

  //////////////////////////////////////////////////////////////////////////
  // ahb-lite fields
  //////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    HTRANS_IDLE, HTRANS_BUSY, HTRANS_NONSEQ, HTRANS_SEQ
  } htrans_e;

  typedef enum logic [2:0] {
    HBURST_SINGLE, HBURST_INCR, HBURST_WRAP4, HBURST_INCR4,
    HBURST_WRAP8, HBURST_INCR8, HBURST_WRAP16, HBURST_INCR16
  } hburst_e;

  typedef enum logic [2:0] {
    HSIZE_BYTE  = 3'd0,
    HSIZE_HWORD = 3'd1,
    HSIZE_WORD  = 3'd2
  } hsize_e;

  typedef enum logic {HRESP_OKAY, HRESP_ERROR} hresp_e;

  // slave data phase
  typedef enum logic [1:0] {IDLE, WAIT, ERR1, ERR2} slv_state_e;

  // config register index, byte address bits [3:2]
  typedef enum logic [1:0] {
    WAIT_CNT, ERR_BASE, ERR_LIMIT, ERR_COUNT
  } cfg_reg_e;

endpackage

/* biu_ahb_bridge.sv */
// core bus interface unit to ahb-lite master bridge
// single transfers and INCR/WRAP bursts, burst aborted on ERROR
`timescale 1ns/1ps
`include "biu_ahb_params.svh"

module biu_ahb_bridge (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  // core side
  input  logic                    biu_stb_i,
  output logic                    biu_stb_ack_o,
  output logic                    biu_d_ack_o,
  input  logic [`BIU_PLEN-1:0]    biu_adri_i,
  output logic [`BIU_PLEN-1:0]    biu_adro_o,
  input  logic [2:0]              biu_size_i,
  input  biu_ahb_pkg::biu_burst_e biu_type_i,
  input  logic [2:0]              biu_prot_i,   // [0] data, [1] priv, [2] cacheable
  input  logic                    biu_lock_i,
  input  logic                    biu_we_i,
  input  logic [`BIU_XLEN-1:0]    biu_d_i,
  output logic [`BIU_XLEN-1:0]    biu_q_o,
  output logic                    biu_ack_o,
  output logic                    biu_err_o,
  // ahb-lite master
  output logic                    hsel_o,
  output logic [`BIU_PLEN-1:0]    haddr_o,
  output logic [`BIU_XLEN-1:0]    hwdata_o,
  output logic                    hwrite_o,
  output biu_ahb_pkg::hsize_e     hsize_o,
  output biu_ahb_pkg::hburst_e    hburst_o,
  output logic [3:0]              hprot_o,
  output biu_ahb_pkg::htrans_e    htrans_o,
  output logic                    hmastlock_o,
  input  logic                    hready_i,
  input  biu_ahb_pkg::hresp_e     hresp_i,
  input  logic [`BIU_XLEN-1:0]    hrdata_i
);

  ////////////////////////////////////////////////////////////////////////////
  // conversions
  ////////////////////////////////////////////////////////////////////////////

  function automatic biu_ahb_pkg::hsize_e size2hsize(input logic [2:0] size);
    case (size)
      3'd0:    return biu_ahb_pkg::HSIZE_BYTE;
      3'd1:    return biu_ahb_pkg::HSIZE_HWORD;
      default: return biu_ahb_pkg::HSIZE_WORD;  // nothing wider on 32 bits
    endcase
  endfunction

  // beats minus one
  function automatic logic [3:0] type2cnt(input biu_ahb_pkg::biu_burst_e t);
    case (t)
      biu_ahb_pkg::WRAP4,  biu_ahb_pkg::INCR4:  return 4'd3;
      biu_ahb_pkg::WRAP8,  biu_ahb_pkg::INCR8:  return 4'd7;
      biu_ahb_pkg::WRAP16, biu_ahb_pkg::INCR16: return 4'd15;
      default:                                  return 4'd0;  // SINGLE, INCR
    endcase
  endfunction

  function automatic biu_ahb_pkg::hburst_e type2hburst(input biu_ahb_pkg::biu_burst_e t);
    case (t)
      biu_ahb_pkg::INCR:   return biu_ahb_pkg::HBURST_INCR;
      biu_ahb_pkg::WRAP4:  return biu_ahb_pkg::HBURST_WRAP4;
      biu_ahb_pkg::INCR4:  return biu_ahb_pkg::HBURST_INCR4;
      biu_ahb_pkg::WRAP8:  return biu_ahb_pkg::HBURST_WRAP8;
      biu_ahb_pkg::INCR8:  return biu_ahb_pkg::HBURST_INCR8;
      biu_ahb_pkg::WRAP16: return biu_ahb_pkg::HBURST_WRAP16;
      biu_ahb_pkg::INCR16: return biu_ahb_pkg::HBURST_INCR16;
      default:             return biu_ahb_pkg::HBURST_SINGLE;
    endcase
  endfunction

  // next word address, upper bits frozen on wrapping bursts
  function automatic logic [`BIU_PLEN-1:0] nxt_addr(input logic [`BIU_PLEN-1:0] addr,
                                                    input biu_ahb_pkg::hburst_e hb);
    logic [`BIU_PLEN-1:0] lin;
    lin = {addr[`BIU_PLEN-1:2] + 1'b1, 2'b00};
    case (hb)
      biu_ahb_pkg::HBURST_WRAP4:  return {addr[`BIU_PLEN-1:4], lin[3:0]};  // 16 byte block
      biu_ahb_pkg::HBURST_WRAP8:  return {addr[`BIU_PLEN-1:5], lin[4:0]};
      biu_ahb_pkg::HBURST_WRAP16: return {addr[`BIU_PLEN-1:6], lin[5:0]};
      default:                    return lin;
    endcase
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////////////////////

  logic [3:0] burst_cnt;   // beats still to issue
  logic       data_ena;    // beat in address phase
  logic       data_ena_d;  // beat in data phase

  assign biu_stb_ack_o = hready_i & ~|burst_cnt & biu_stb_i & ~biu_err_o;

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      burst_cnt   <= '0;
      data_ena    <= 1'b0;
      biu_err_o   <= 1'b0;
      hsel_o      <= 1'b0;
      haddr_o     <= '0;
      hwrite_o    <= 1'b0;
      hsize_o     <= biu_ahb_pkg::HSIZE_WORD;
      hburst_o    <= biu_ahb_pkg::HBURST_SINGLE;
      hprot_o     <= `HPROT_RST;
      htrans_o    <= biu_ahb_pkg::HTRANS_IDLE;
      hmastlock_o <= 1'b0;
    end else begin
      biu_err_o <= 1'b0;  // one cycle pulse
      if (hready_i) begin
        if (burst_cnt == '0) begin
          if (biu_stb_ack_o) begin  // new request, first beat
            data_ena    <= 1'b1;
            burst_cnt   <= type2cnt(biu_type_i);
            hsel_o      <= 1'b1;
            htrans_o    <= biu_ahb_pkg::HTRANS_NONSEQ;
            haddr_o     <= biu_adri_i;
            hwrite_o    <= biu_we_i;
            hsize_o     <= size2hsize(biu_size_i);
            hburst_o    <= type2hburst(biu_type_i);
            hprot_o     <= {biu_prot_i[2], 1'b0, biu_prot_i[1], biu_prot_i[0]};
            hmastlock_o <= biu_lock_i;
          end else begin
            data_ena    <= 1'b0;
            hsel_o      <= 1'b0;
            htrans_o    <= biu_ahb_pkg::HTRANS_IDLE;
            hmastlock_o <= biu_lock_i;  // lock may persist between transfers
          end
        end else begin  // burst continues
          data_ena  <= 1'b1;
          burst_cnt <= burst_cnt - 1'b1;
          htrans_o  <= biu_ahb_pkg::HTRANS_SEQ;
          haddr_o   <= nxt_addr(haddr_o, hburst_o);
        end
      end else if (hresp_i == biu_ahb_pkg::HRESP_ERROR) begin
        // first error cycle, drop rest of burst
        burst_cnt <= '0;
        data_ena  <= 1'b0;
        hsel_o    <= 1'b0;
        htrans_o  <= biu_ahb_pkg::HTRANS_IDLE;
        biu_err_o <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // data phase
  ////////////////////////////////////////////////////////////////////////////

  assign biu_d_ack_o = hready_i & data_ena & hwrite_o;

  always_ff @(posedge HCLK) begin
    if (biu_d_ack_o) hwdata_o <= biu_d_i;    // into data phase
    if (hready_i)    biu_adro_o <= haddr_o;  // address of beat in data phase
  end

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) data_ena_d <= 1'b0;
    else if (hready_i) data_ena_d <= data_ena;
  end

  assign biu_q_o   = hrdata_i;
  assign biu_ack_o = hready_i & data_ena_d & (hresp_i == biu_ahb_pkg::HRESP_OKAY);

  // burst never resumes out of idle
  a_no_seq_after_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    htrans_o == biu_ahb_pkg::HTRANS_IDLE |=> htrans_o != biu_ahb_pkg::HTRANS_SEQ);

  // slave stall freezes the address phase
  a_addr_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    !hready_i |=> $stable(haddr_o));

endmodule

/* ahb_sram_slave.sv */
// ahb-lite word sram slave
// programmable wait states, configurable error window
`timescale 1ns/1ps
`include "biu_ahb_params.svh"

module ahb_sram_slave (
  input  logic                     HCLK,
  input  logic                     HRESETn,
  input  logic                     hsel_i,
  input  logic [`BIU_PLEN-1:0]     haddr_i,
  input  logic [`BIU_XLEN-1:0]     hwdata_i,
  input  logic                     hwrite_i,
  input  biu_ahb_pkg::hsize_e      hsize_i,
  input  biu_ahb_pkg::hburst_e     hburst_i,
  input  biu_ahb_pkg::htrans_e     htrans_i,
  output logic                     hready_o,
  output biu_ahb_pkg::hresp_e      hresp_o,
  output logic [`BIU_XLEN-1:0]     hrdata_o,
  // config block side
  input  logic [`CFG_WAIT_W-1:0]   wait_cnt_i,
  input  logic [`SRAM_AW-1:0]      err_base_i,
  input  logic [`SRAM_AW-1:0]      err_limit_i,
  output logic                     err_pulse_o
);

  logic [`BIU_XLEN-1:0]    mem [0:`SRAM_WORDS-1];
  biu_ahb_pkg::slv_state_e state;
  logic [`CFG_WAIT_W-1:0]  wait_left;  // stall cycles remaining
  logic                    accept;     // address phase taken this cycle
  logic [`SRAM_AW-1:0]     ap_idx;
  logic                    ap_hit;     // address phase inside error window
  logic                    dp_vld;
  logic                    dp_write;
  logic                    dp_err;
  logic [`SRAM_AW-1:0]     dp_idx;

  ////////////////////////////////////////////////////////////////////////////
  // address phase
  ////////////////////////////////////////////////////////////////////////////

  assign ap_idx = haddr_i[`SRAM_AW+1:2];  // word index
  assign ap_hit = (ap_idx >= err_base_i) && (ap_idx <= err_limit_i);
  assign accept = hready_o & hsel_i &
                  (htrans_i == biu_ahb_pkg::HTRANS_NONSEQ ||
                   htrans_i == biu_ahb_pkg::HTRANS_SEQ);

  // ready in idle and on the last error cycle
  assign hready_o    = (state == biu_ahb_pkg::IDLE) || (state == biu_ahb_pkg::ERR2);
  assign hresp_o     = (state == biu_ahb_pkg::ERR1 || state == biu_ahb_pkg::ERR2) ?
                       biu_ahb_pkg::HRESP_ERROR : biu_ahb_pkg::HRESP_OKAY;
  assign err_pulse_o = (state == biu_ahb_pkg::ERR1);  // once per error
  assign hrdata_o    = mem[dp_idx];

  ////////////////////////////////////////////////////////////////////////////
  // data phase fsm
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      state     <= biu_ahb_pkg::IDLE;
      wait_left <= '0;
      dp_vld    <= 1'b0;
    end else begin
      case (state)
        biu_ahb_pkg::WAIT: begin
          wait_left <= wait_left - 1'b1;
          if (wait_left == 1) state <= dp_err ? biu_ahb_pkg::ERR1 : biu_ahb_pkg::IDLE;
        end
        biu_ahb_pkg::ERR1: state <= biu_ahb_pkg::ERR2;
        default: begin  // idle or err2, next address phase may start
          dp_vld <= accept;
          if (!accept) begin
            state <= biu_ahb_pkg::IDLE;
          end else if (wait_cnt_i != '0) begin
            state     <= biu_ahb_pkg::WAIT;
            wait_left <= wait_cnt_i;
          end else begin
            state <= ap_hit ? biu_ahb_pkg::ERR1 : biu_ahb_pkg::IDLE;
          end
        end
      endcase
    end
  end

  // payload and memory
  always_ff @(posedge HCLK) begin
    if (accept) begin
      dp_idx   <= ap_idx;
      dp_write <= hwrite_i;
      dp_err   <= ap_hit;
    end
    // error beats never reach idle, memory stays untouched
    if (state == biu_ahb_pkg::IDLE && dp_vld && dp_write) mem[dp_idx] <= hwdata_i;
  end

  // error response is exactly two cycles
  a_err2_after_err1: assert property (@(posedge HCLK) disable iff (!HRESETn)
    err_pulse_o |=> hresp_o == biu_ahb_pkg::HRESP_ERROR && hready_o);

  // stall always ends back in idle with hready high
  a_wait_to_idle: assert property (@(posedge HCLK) disable iff (!HRESETn)
    state == biu_ahb_pkg::WAIT && !dp_err |-> ##[1:15]
    (state == biu_ahb_pkg::IDLE && hready_o));

  // word transfers only, SEQ only inside a burst
  a_word_burst: assert property (@(posedge HCLK) disable iff (!HRESETn)
    accept |-> hsize_i == biu_ahb_pkg::HSIZE_WORD &&
    !(htrans_i == biu_ahb_pkg::HTRANS_SEQ && hburst_i == biu_ahb_pkg::HBURST_SINGLE));

endmodule

/* ahb_slave_cfg.sv */
// axi4-lite register block for the sram slave
// wait states, error window, saturating error counter
`timescale 1ns/1ps
`include "biu_ahb_params.svh"

module ahb_slave_cfg (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  // axi4-lite slave
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  input  logic [`CFG_AW-1:0]      s_awaddr_i,
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  input  logic [`BIU_XLEN-1:0]    s_wdata_i,
  output logic                    s_bvalid_o,
  output logic [1:0]              s_bresp_o,
  input  logic                    s_bready_i,
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  input  logic [`CFG_AW-1:0]      s_araddr_i,
  output logic                    s_rvalid_o,
  output logic [`BIU_XLEN-1:0]    s_rdata_o,
  output logic [1:0]              s_rresp_o,
  input  logic                    s_rready_i,
  // slave control
  output logic [`CFG_WAIT_W-1:0]  wait_cnt_o,
  output logic [`SRAM_AW-1:0]     err_base_o,
  output logic [`SRAM_AW-1:0]     err_limit_o,
  input  logic                    err_pulse_i
);

  logic                  wr_rdy;   // aw and w ready together
  logic                  wr_hs;
  logic                  rd_hs;
  logic [`CFG_CNT_W-1:0] err_cnt;
  biu_ahb_pkg::cfg_reg_e wr_reg;
  biu_ahb_pkg::cfg_reg_e rd_reg;

  assign wr_reg = biu_ahb_pkg::cfg_reg_e'(s_awaddr_i[3:2]);
  assign rd_reg = biu_ahb_pkg::cfg_reg_e'(s_araddr_i[3:2]);

  assign s_awready_o = wr_rdy;
  assign s_wready_o  = wr_rdy;
  assign wr_hs       = wr_rdy & s_awvalid_i & s_wvalid_i;
  assign rd_hs       = s_arready_o & s_arvalid_i;
  assign s_bresp_o   = 2'b00;  // always OKAY
  assign s_rresp_o   = 2'b00;

  ////////////////////////////////////////////////////////////////////////////
  // handshakes
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wr_rdy      <= 1'b0;
      s_bvalid_o  <= 1'b0;
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
    end else begin
      // no new address while a response is pending
      wr_rdy      <= s_awvalid_i & s_wvalid_i & ~wr_rdy & ~s_bvalid_o;
      s_arready_o <= s_arvalid_i & ~s_arready_o & ~s_rvalid_o;
      if (wr_hs) s_bvalid_o <= 1'b1;
      else if (s_bready_i) s_bvalid_o <= 1'b0;
      if (rd_hs) s_rvalid_o <= 1'b1;
      else if (s_rready_i) s_rvalid_o <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK or negedge HRESETn) begin
    if (!HRESETn) begin
      wait_cnt_o  <= `CFG_WAIT_RST;
      err_base_o  <= `CFG_ERR_BASE_RST;
      err_limit_o <= `CFG_ERR_LIMIT_RST;
      err_cnt     <= '0;
    end else begin
      if (wr_hs && wr_reg == biu_ahb_pkg::WAIT_CNT)  wait_cnt_o  <= s_wdata_i[`CFG_WAIT_W-1:0];
      if (wr_hs && wr_reg == biu_ahb_pkg::ERR_BASE)  err_base_o  <= s_wdata_i[`SRAM_AW-1:0];
      if (wr_hs && wr_reg == biu_ahb_pkg::ERR_LIMIT) err_limit_o <= s_wdata_i[`SRAM_AW-1:0];
      // any write clears, otherwise count up and stick at max
      if (wr_hs && wr_reg == biu_ahb_pkg::ERR_COUNT) err_cnt <= '0;
      else if (err_pulse_i && err_cnt != '1) err_cnt <= err_cnt + 1'b1;
    end
  end

  // read data held with rvalid
  always_ff @(posedge HCLK) begin
    if (rd_hs) begin
      case (rd_reg)
        biu_ahb_pkg::WAIT_CNT:  s_rdata_o <= `BIU_XLEN'(wait_cnt_o);
        biu_ahb_pkg::ERR_BASE:  s_rdata_o <= `BIU_XLEN'(err_base_o);
        biu_ahb_pkg::ERR_LIMIT: s_rdata_o <= `BIU_XLEN'(err_limit_o);
        default:                s_rdata_o <= `BIU_XLEN'(err_cnt);
      endcase
    end
  end

  a_bvalid_hold: assert property (@(posedge HCLK) disable iff (!HRESETn)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o);

endmodule

/* biu_ahb_subsys.sv */
// biu subsystem top, bridge to ahb-lite sram slave
// slave behavior set over axi4-lite
`timescale 1ns/1ps
`include "biu_ahb_params.svh"

module biu_ahb_subsys (
  input  logic                    HCLK,
  input  logic                    HRESETn,
  // core biu port
  input  logic                    biu_stb_i,
  output logic                    biu_stb_ack_o,
  output logic                    biu_d_ack_o,
  input  logic [`BIU_PLEN-1:0]    biu_adri_i,
  output logic [`BIU_PLEN-1:0]    biu_adro_o,
  input  logic [2:0]              biu_size_i,
  input  biu_ahb_pkg::biu_burst_e biu_type_i,
  input  logic [2:0]              biu_prot_i,
  input  logic                    biu_lock_i,
  input  logic                    biu_we_i,
  input  logic [`BIU_XLEN-1:0]    biu_d_i,
  output logic [`BIU_XLEN-1:0]    biu_q_o,
  output logic                    biu_ack_o,
  output logic                    biu_err_o,
  // axi4-lite config port
  input  logic                    s_awvalid_i,
  output logic                    s_awready_o,
  input  logic [`CFG_AW-1:0]      s_awaddr_i,
  input  logic                    s_wvalid_i,
  output logic                    s_wready_o,
  input  logic [`BIU_XLEN-1:0]    s_wdata_i,
  output logic                    s_bvalid_o,
  output logic [1:0]              s_bresp_o,
  input  logic                    s_bready_i,
  input  logic                    s_arvalid_i,
  output logic                    s_arready_o,
  input  logic [`CFG_AW-1:0]      s_araddr_i,
  output logic                    s_rvalid_o,
  output logic [`BIU_XLEN-1:0]    s_rdata_o,
  output logic [1:0]              s_rresp_o,
  input  logic                    s_rready_i
);

  // ahb-lite, single slave so hready is its hreadyout
  logic                  hsel;
  logic [`BIU_PLEN-1:0]  haddr;
  logic [`BIU_XLEN-1:0]  hwdata;
  logic [`BIU_XLEN-1:0]  hrdata;
  logic                  hwrite;
  biu_ahb_pkg::hsize_e   hsize;
  biu_ahb_pkg::hburst_e  hburst;
  logic [3:0]            hprot;   // master side only, slave does no checks
  biu_ahb_pkg::htrans_e  htrans;
  logic                  hmastlock;
  logic                  hready;
  biu_ahb_pkg::hresp_e   hresp;

  // slave control
  logic [`CFG_WAIT_W-1:0] wait_cnt;
  logic [`SRAM_AW-1:0]    err_base;
  logic [`SRAM_AW-1:0]    err_limit;
  logic                   err_pulse;

  biu_ahb_bridge i_biu_ahb_bridge (
    .HCLK, .HRESETn,
    .biu_stb_i, .biu_stb_ack_o, .biu_d_ack_o, .biu_adri_i, .biu_adro_o,
    .biu_size_i, .biu_type_i, .biu_prot_i, .biu_lock_i, .biu_we_i,
    .biu_d_i, .biu_q_o, .biu_ack_o, .biu_err_o,
    .hsel_o      (hsel),
    .haddr_o     (haddr),
    .hwdata_o    (hwdata),
    .hwrite_o    (hwrite),
    .hsize_o     (hsize),
    .hburst_o    (hburst),
    .hprot_o     (hprot),
    .htrans_o    (htrans),
    .hmastlock_o (hmastlock),
    .hready_i    (hready),
    .hresp_i     (hresp),
    .hrdata_i    (hrdata)
  );

  ahb_sram_slave i_ahb_sram_slave (
    .HCLK, .HRESETn,
    .hsel_i      (hsel),
    .haddr_i     (haddr),
    .hwdata_i    (hwdata),
    .hwrite_i    (hwrite),
    .hsize_i     (hsize),
    .hburst_i    (hburst),
    .htrans_i    (htrans),
    .hready_o    (hready),
    .hresp_o     (hresp),
    .hrdata_o    (hrdata),
    .wait_cnt_i  (wait_cnt),
    .err_base_i  (err_base),
    .err_limit_i (err_limit),
    .err_pulse_o (err_pulse)
  );

  ahb_slave_cfg i_ahb_slave_cfg (
    .HCLK, .HRESETn,
    .s_awvalid_i, .s_awready_o, .s_awaddr_i,
    .s_wvalid_i, .s_wready_o, .s_wdata_i,
    .s_bvalid_o, .s_bresp_o, .s_bready_i,
    .s_arvalid_i, .s_arready_o, .s_araddr_i,
    .s_rvalid_o, .s_rdata_o, .s_rresp_o, .s_rready_i,
    .wait_cnt_o  (wait_cnt),
    .err_base_o  (err_base),
    .err_limit_o (err_limit),
    .err_pulse_i (err_pulse)
  );

endmodule

/* tb_biu_ahb_subsys.sv */
// testbench for the biu to ahb-lite subsystem
// acts as core and axi4-lite host, replays tb_input.txt against a memory model
`timescale 1ns/1ps
`include "biu_ahb_params.svh"

module tb_biu_ahb_subsys;

  localparam int WAIT_LIMIT = 200;  // cycles allowed per wait

  logic                    HCLK;
  logic                    HRESETn;
  // core side
  logic                    biu_stb_i;
  logic                    biu_stb_ack_o;
  logic                    biu_d_ack_o;
  logic [`BIU_PLEN-1:0]    biu_adri_i;
  logic [`BIU_PLEN-1:0]    biu_adro_o;
  logic [2:0]              biu_size_i;
  biu_ahb_pkg::biu_burst_e biu_type_i;
  logic [2:0]              biu_prot_i;
  logic                    biu_lock_i;
  logic                    biu_we_i;
  logic [`BIU_XLEN-1:0]    biu_d_i;
  logic [`BIU_XLEN-1:0]    biu_q_o;
  logic                    biu_ack_o;
  logic                    biu_err_o;
  // axi4-lite host
  logic                    s_awvalid_i;
  logic                    s_awready_o;
  logic [`CFG_AW-1:0]      s_awaddr_i;
  logic                    s_wvalid_i;
  logic                    s_wready_o;
  logic [`BIU_XLEN-1:0]    s_wdata_i;
  logic                    s_bvalid_o;
  logic [1:0]              s_bresp_o;
  logic                    s_bready_i;
  logic                    s_arvalid_i;
  logic                    s_arready_o;
  logic [`CFG_AW-1:0]      s_araddr_i;
  logic                    s_rvalid_o;
  logic [`BIU_XLEN-1:0]    s_rdata_o;
  logic [1:0]              s_rresp_o;
  logic                    s_rready_i;

  // reference state
  logic [`BIU_XLEN-1:0] mem_model [0:`SRAM_WORDS-1];
  logic [`BIU_XLEN-1:0] cfg_model [0:3];   // by register index
  logic [`BIU_XLEN-1:0] words     [0:15];  // operands of current line
  int                   n_ops;

  biu_ahb_subsys i_biu_ahb_subsys (.*);

  always #50 HCLK = ~HCLK;  // 100 ns period

  ////////////////////////////////////////////////////////////////////////////
  // reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] act,
                             input logic [31:0] exp);
    if (act !== exp)
      abort_run($sformatf("Error: %s is 0x%h, expected 0x%h", name, act, exp));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference rules
  ////////////////////////////////////////////////////////////////////////////

  function automatic int burst_beats(input biu_ahb_pkg::biu_burst_e btype);
    case (btype)
      biu_ahb_pkg::WRAP4,  biu_ahb_pkg::INCR4:  return 4;
      biu_ahb_pkg::WRAP8,  biu_ahb_pkg::INCR8:  return 8;
      biu_ahb_pkg::WRAP16, biu_ahb_pkg::INCR16: return 16;
      default:                                  return 1;  // open INCR taken as one beat
    endcase
  endfunction

  // beat k address, wrapping bursts stay inside their aligned block
  function automatic logic [31:0] beat_addr(input logic [31:0] start,
                                            input biu_ahb_pkg::biu_burst_e btype,
                                            input int k);
    logic [31:0] lin;
    logic [31:0] span;  // block size in bytes
    lin  = start + 4 * k;
    span = 4 * burst_beats(btype);
    if (btype == biu_ahb_pkg::WRAP4 || btype == biu_ahb_pkg::WRAP8 ||
        btype == biu_ahb_pkg::WRAP16) begin
      return (start & ~(span - 1)) | (lin & (span - 1));
    end else begin
      return lin;
    end
  endfunction

  // inclusive word window, empty while base is above limit
  function automatic logic in_err_window(input logic [31:0] a);
    logic [31:0] idx;
    idx = a[`SRAM_AW+1:2];
    return idx >= cfg_model[biu_ahb_pkg::ERR_BASE] && idx <= cfg_model[biu_ahb_pkg::ERR_LIMIT];
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // axi4-lite host
  ////////////////////////////////////////////////////////////////////////////

  task automatic cfg_write(input logic [31:0] addr, input logic [31:0] data);
    int t;
    @(negedge HCLK);
    s_awvalid_i = 1'b1;
    s_awaddr_i  = addr[`CFG_AW-1:0];
    s_wvalid_i  = 1'b1;
    s_wdata_i   = data;
    s_bready_i  = 1'b1;
    t = 0;
    @(posedge HCLK);
    while (!(s_awready_o && s_wready_o)) begin  // aw and w taken together
      t++;
      if (t > WAIT_LIMIT) abort_run("timed out waiting for AWREADY and WREADY");
      @(posedge HCLK);
    end
    @(negedge HCLK);
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    t = 0;
    @(posedge HCLK);
    while (!s_bvalid_o) begin
      t++;
      if (t > WAIT_LIMIT) abort_run("timed out waiting for BVALID");
      @(posedge HCLK);
    end
    check_value("s_bresp_o", s_bresp_o, 2'b00);
    @(negedge HCLK);
    s_bready_i = 1'b0;
    case (biu_ahb_pkg::cfg_reg_e'(addr[3:2]))  // track register contents
      biu_ahb_pkg::WAIT_CNT:  cfg_model[biu_ahb_pkg::WAIT_CNT]  = data & {`CFG_WAIT_W{1'b1}};
      biu_ahb_pkg::ERR_BASE:  cfg_model[biu_ahb_pkg::ERR_BASE]  = data & {`SRAM_AW{1'b1}};
      biu_ahb_pkg::ERR_LIMIT: cfg_model[biu_ahb_pkg::ERR_LIMIT] = data & {`SRAM_AW{1'b1}};
      default:                cfg_model[biu_ahb_pkg::ERR_COUNT] = '0;  // any write clears
    endcase
  endtask

  task automatic cfg_read(input logic [31:0] addr, output logic [31:0] data);
    int t;
    @(negedge HCLK);
    s_arvalid_i = 1'b1;
    s_araddr_i  = addr[`CFG_AW-1:0];
    s_rready_i  = 1'b1;
    t = 0;
    @(posedge HCLK);
    while (!s_arready_o) begin
      t++;
      if (t > WAIT_LIMIT) abort_run("timed out waiting for ARREADY");
      @(posedge HCLK);
    end
    @(negedge HCLK);
    s_arvalid_i = 1'b0;
    t = 0;
    @(posedge HCLK);
    while (!s_rvalid_o) begin
      t++;
      if (t > WAIT_LIMIT) abort_run("timed out waiting for RVALID");
      @(posedge HCLK);
    end
    data = s_rdata_o;
    check_value("s_rresp_o", s_rresp_o, 2'b00);
    @(negedge HCLK);
    s_rready_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // core side bursts
  ////////////////////////////////////////////////////////////////////////////

  // nwords 0 on a read means compare with the memory model
  task automatic run_burst(input logic we, input logic [2:0] code,
                           input logic [31:0] addr, input int nwords);
    biu_ahb_pkg::biu_burst_e btype;
    int          beats;
    int          first_err;  // beat that should fail, beats if none
    int          acks;
    int          nd;         // write beats already handed over
    int          t;
    int          k;
    logic        seen_err;
    logic [31:0] a;
    btype = biu_ahb_pkg::biu_burst_e'(code);
    beats = burst_beats(btype);
    if (nwords != beats && !(nwords == 0 && !we))
      abort_run("tb_input.txt gives the wrong number of words for a burst");
    first_err = beats;
    for (k = 0; k < beats; k++)
      if (first_err == beats && in_err_window(beat_addr(addr, btype, k))) first_err = k;
    @(negedge HCLK);
    biu_stb_i  = 1'b1;
    biu_adri_i = addr;
    biu_type_i = btype;
    biu_we_i   = we;
    biu_d_i    = words[0];
    t = 0;
    @(posedge HCLK);
    while (!biu_stb_ack_o) begin
      t++;
      if (t > WAIT_LIMIT) abort_run("timed out waiting for the request to be accepted");
      @(posedge HCLK);
    end
    @(negedge HCLK);
    biu_stb_i = 1'b0;
    acks      = 0;
    nd        = 0;
    seen_err  = 1'b0;
    t         = 0;
    while (acks < beats && !seen_err) begin
      @(posedge HCLK);
      t++;
      if (biu_d_ack_o) nd++;
      if (biu_ack_o) begin
        a = beat_addr(addr, btype, acks);
        check_value("biu_adro_o", biu_adro_o, a);
        if (we)
          mem_model[a[`SRAM_AW+1:2]] = words[acks];
        else
          check_value("biu_q_o", biu_q_o, (nwords == 0) ? mem_model[a[`SRAM_AW+1:2]] : words[acks]);
        acks++;
        t = 0;
      end
      if (biu_err_o) seen_err = 1'b1;
      if (t > WAIT_LIMIT) abort_run("timed out waiting for a beat to complete");
      @(negedge HCLK);
      biu_d_i = (nd < beats) ? words[nd] : words[0];
    end
    check_value("biu_ack_o count", acks, first_err);
    check_value("biu_err_o", seen_err, first_err < beats);
    if (first_err < beats && cfg_model[biu_ahb_pkg::ERR_COUNT] != 32'hffff)
      cfg_model[biu_ahb_pkg::ERR_COUNT]++;  // one per error response
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int              fd;
    int              r;
    int              nw;
    int              i;
    logic [8*8-1:0]  op;
    logic [8*256-1:0] rest;
    logic [31:0]     code;
    logic [31:0]     addr;
    logic [31:0]     rdata;
    HCLK        = 1'b0;
    HRESETn     = 1'b0;
    biu_stb_i   = 1'b0;
    biu_adri_i  = '0;
    biu_size_i  = 3'd2;      // word
    biu_type_i  = biu_ahb_pkg::SINGLE;
    biu_prot_i  = 3'b011;    // data, privileged
    biu_lock_i  = 1'b0;
    biu_we_i    = 1'b0;
    biu_d_i     = '0;
    s_awvalid_i = 1'b0;
    s_awaddr_i  = '0;
    s_wvalid_i  = 1'b0;
    s_wdata_i   = '0;
    s_bready_i  = 1'b0;
    s_arvalid_i = 1'b0;
    s_araddr_i  = '0;
    s_rready_i  = 1'b0;
    n_ops       = 0;
    for (i = 0; i < `SRAM_WORDS; i++) mem_model[i] = '0;
    cfg_model[biu_ahb_pkg::WAIT_CNT]  = '0;
    cfg_model[biu_ahb_pkg::ERR_BASE]  = {`SRAM_AW{1'b1}};  // empty window
    cfg_model[biu_ahb_pkg::ERR_LIMIT] = '0;
    cfg_model[biu_ahb_pkg::ERR_COUNT] = '0;
    fd = $fopen("tb_input.txt", "r");
    if (fd == 0) abort_run("could not open tb_input.txt");
    repeat (10) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b1;
    r = $fscanf(fd, "%s", op);
    while (r == 1) begin
      if (op == "#") begin
        r = $fgets(rest, fd);  // skip comment line
      end else begin
        if ($fscanf(fd, "%h %h %d", code, addr, nw) != 3 || nw < 0 || nw > 16)
          abort_run("malformed line in tb_input.txt");
        for (i = 0; i < nw; i++)
          if ($fscanf(fd, "%h", words[i]) != 1) abort_run("missing data word in tb_input.txt");
        case (op)
          "CFGW": cfg_write(addr, words[0]);
          "CFGR": begin
            cfg_read(addr, rdata);
            check_value("s_rdata_o", rdata, (nw == 0) ? cfg_model[addr[3:2]] : words[0]);
          end
          "WR":    run_burst(1'b1, code[2:0], addr, nw);
          "RD":    run_burst(1'b0, code[2:0], addr, nw);
          default: abort_run("unknown opcode in tb_input.txt");
        endcase
        n_ops++;
      end
      r = $fscanf(fd, "%s", op);
    end
    $fclose(fd);
    if (n_ops > 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      abort_run("tb_input.txt held no operations");
    end
  end

endmodule

/* tb_input.txt */
# op burst(biu_burst_e code, hex) addr(hex) n(dec) then n hex words
# words are write data or expected data, n of 0 on RD or CFGR compares with the model
CFGR 0 c 1 00000000
CFGR 0 4 1 000000ff
CFGW 0 0 1 00000005
CFGR 0 0 1 00000005
CFGW 0 4 1 00000010
CFGW 0 8 1 00000020
CFGR 0 4 1 00000010
CFGR 0 8 0
CFGW 0 4 1 000000ff
CFGW 0 8 1 00000000
CFGW 0 0 1 00000000
WR 0 40 1 cafe0040
RD 0 40 1 cafe0040
WR 3 100 4 11110100 11110104 11110108 1111010c
RD 3 100 0
WR 5 200 8 22220200 22220204 22220208 2222020c 22220210 22220214 22220218 2222021c
RD 5 200 8 22220200 22220204 22220208 2222020c 22220210 22220214 22220218 2222021c
WR 2 118 4 33330118 3333011c 33330110 33330114
RD 2 118 0
WR 4 234 8 44440234 44440238 4444023c 44440220 44440224 44440228 4444022c 44440230
RD 7 200 0
CFGW 0 0 1 00000003
CFGR 0 0 1 00000003
RD 3 100 0
RD 2 118 0
RD 4 234 0
WR 5 300 8 55550300 55550304 55550308 5555030c 55550310 55550314 55550318 5555031c
RD 5 300 0
CFGW 0 4 1 000000c2
CFGW 0 8 1 000000c3
WR 5 300 8 66660300 66660304 66660308 6666030c 66660310 66660314 66660318 6666031c
CFGW 0 0 1 00000000
RD 0 308 0
WR 0 30c 1 7777030c
CFGR 0 c 1 00000003
CFGW 0 4 1 000000ff
CFGW 0 8 1 00000000
RD 5 300 0
CFGW 0 c 1 00000000
CFGR 0 c 0

/* sources.f */
+incdir+.
biu_ahb_pkg.sv
biu_ahb_bridge.sv
ahb_sram_slave.sv
ahb_slave_cfg.sv
biu_ahb_subsys.sv
tb_biu_ahb_subsys.sv

/* Bender.yml */
package:
  name: biu_ahb_subsys

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - biu_ahb_pkg.sv
      - biu_ahb_bridge.sv
      - ahb_sram_slave.sv
      - ahb_slave_cfg.sv
      - biu_ahb_subsys.sv

  - target: test
    include_dirs:
      - .
    files:
      - tb_biu_ahb_subsys.sv
